// File: verilog/wram_pkg.sv
// Shared definitions for the work-RAM sharing pipeline
// Widths, depth, data types and the command source tag

package wram_pkg;

    // Shared RAM size in bytes
    localparam int WRAM_DEPTH = 8192;

    // Index width follows the depth
    localparam int WRAM_INDEX_W = $clog2(WRAM_DEPTH);

    // Byte offset inside either window
    typedef logic [WRAM_INDEX_W-1:0] wram_index_t;

    // One stored byte
    typedef logic [7:0] wram_data_t;

    // CPU bus address
    typedef logic [15:0] cpu_addr_t;

    // Soft-core bus address
    typedef logic [22:0] rv_addr_t;

    // Origin of a command, carried along to route the result
    typedef enum logic {
        SRC_CPU = 1'b0,
        SRC_RV  = 1'b1
    } wram_src_e;

endpackage

// File: verilog/wram_cmd_if.sv
// Stage-to-stage bus for one RAM command or one read result
// No ready signal, the receiver takes every valid beat

interface wram_cmd_if import wram_pkg::*; ();

    logic        valid;
    logic        we;
    wram_src_e   src;
    wram_index_t index;
    // Write data on the command bus, read data on the result bus
    wram_data_t  data;
    // Soft-core access that missed the window
    logic        out_of_window;

    modport sender (
        output valid,
        output we,
        output src,
        output index,
        output data,
        output out_of_window
    );

    modport receiver (
        input valid,
        input we,
        input src,
        input index,
        input data,
        input out_of_window
    );

endinterface

// File: verilog/wram_request_stage.sv
// Request stage: window decode for both requesters, arbitration,
// soft-core pending flag and the registered RAM command

module wram_request_stage import wram_pkg::*; #(
    parameter cpu_addr_t CPU_WINDOW_BASE = 16'h6000,
    parameter rv_addr_t  RV_WINDOW_BASE  = 23'h706000
) (
    input  logic       i_clk,
    input  logic       i_resetn,
    input  logic       i_wram_load_ongoing,
    input  logic       i_cpu_valid,
    input  logic       i_cpu_we,
    input  cpu_addr_t  i_cpu_addr,
    input  wram_data_t i_cpu_wdata,
    input  logic       i_rv_req,
    input  logic       i_rv_we,
    input  rv_addr_t   i_rv_addr,
    input  wram_data_t i_rv_wdata,
    input  logic       i_rv_done,
    wram_cmd_if.sender cmd
);

    cpu_addr_t cpu_offset;
    rv_addr_t  rv_offset;
    logic      cpu_in_win;
    logic      rv_in_win;
    logic      cpu_hit;
    logic      rv_eligible;
    logic      rv_grant;
    logic      cpu_grant;
    logic      rv_pending;

    // Window end is exclusive; addresses below the base never match
    assign cpu_offset = i_cpu_addr - CPU_WINDOW_BASE;
    assign rv_offset  = i_rv_addr - RV_WINDOW_BASE;
    assign cpu_in_win = (i_cpu_addr >= CPU_WINDOW_BASE) && (cpu_offset < WRAM_DEPTH);
    assign rv_in_win  = (i_rv_addr >= RV_WINDOW_BASE) && (rv_offset < WRAM_DEPTH);

    // CPU accesses outside the window are simply ignored
    assign cpu_hit     = i_cpu_valid && cpu_in_win;
    assign rv_eligible = i_rv_req && !rv_pending;

    // CPU first, except during a load when the soft core takes the slot
    assign rv_grant  = rv_eligible && (!cpu_hit || i_wram_load_ongoing);
    assign cpu_grant = cpu_hit && !rv_grant;

    always_ff @(posedge i_clk) begin
        if (!i_resetn) begin
            cmd.valid  <= 1'b0;
            rv_pending <= 1'b0;
        end else begin
            cmd.valid <= rv_grant || cpu_grant;
            // One soft-core access in flight until its acknowledge
            if (rv_grant) begin
                rv_pending <= 1'b1;
            end else if (i_rv_done) begin
                rv_pending <= 1'b0;
            end
        end
    end

    // Command payload, only meaningful while valid is set
    always_ff @(posedge i_clk) begin
        if (rv_grant) begin
            cmd.we            <= i_rv_we;
            cmd.src           <= SRC_RV;
            cmd.index         <= rv_offset[WRAM_INDEX_W-1:0];
            cmd.data          <= i_rv_wdata;
            cmd.out_of_window <= !rv_in_win;
        end else begin
            cmd.we            <= i_cpu_we;
            cmd.src           <= SRC_CPU;
            cmd.index         <= cpu_offset[WRAM_INDEX_W-1:0];
            cmd.data          <= i_cpu_wdata;
            cmd.out_of_window <= 1'b0;
        end
    end

endmodule

// File: verilog/wram_array_stage.sv
// Array stage: 8 KB byte RAM with write port and registered read
// Command tags are forwarded alongside the read byte

module wram_array_stage import wram_pkg::*; (
    input  logic         i_clk,
    input  logic         i_resetn,
    wram_cmd_if.receiver cmd,
    wram_cmd_if.sender   rsp
);

    wram_data_t mem [WRAM_DEPTH];

    // Write port, misses of the soft-core window never touch the array
    always_ff @(posedge i_clk) begin
        if (cmd.valid && cmd.we && !cmd.out_of_window) begin
            mem[cmd.index] <= cmd.data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_resetn) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= cmd.valid;
        end
    end

    // Registered read plus the tags of the same command
    always_ff @(posedge i_clk) begin
        if (cmd.valid) begin
            if (cmd.out_of_window) begin
                rsp.data <= '0;
            end else begin
                rsp.data <= mem[cmd.index];
            end
            rsp.we            <= cmd.we;
            rsp.src           <= cmd.src;
            rsp.index         <= cmd.index;
            rsp.out_of_window <= cmd.out_of_window;
        end
    end

endmodule

// File: verilog/wram_response_stage.sv
// Response stage: registered read data for the CPU, acknowledge and
// read data for the soft core, and the done feedback to the request stage

module wram_response_stage import wram_pkg::*; (
    input  logic         i_clk,
    input  logic         i_resetn,
    wram_cmd_if.receiver rsp,
    output logic         o_cpu_rvalid,
    output wram_data_t   o_cpu_rdata,
    output logic         o_rv_ack,
    output wram_data_t   o_rv_rdata,
    output logic         o_rv_done
);

    logic cpu_read;
    logic rv_result;
    logic rv_read;

    // Only CPU reads produce a response, CPU writes end in the array
    assign cpu_read = rsp.valid && (rsp.src == SRC_CPU) && !rsp.we;

    // Every soft-core access is acknowledged, in or out of the window
    assign rv_result = rsp.valid && (rsp.src == SRC_RV);
    assign rv_read   = rv_result && !rsp.we;

    always_ff @(posedge i_clk) begin
        if (!i_resetn) begin
            o_cpu_rvalid <= 1'b0;
            o_rv_ack     <= 1'b0;
        end else begin
            o_cpu_rvalid <= cpu_read;
            o_rv_ack     <= rv_result;
        end
    end

    // Data registers hold their last value between responses
    always_ff @(posedge i_clk) begin
        if (cpu_read) begin
            o_cpu_rdata <= rsp.data;
        end
        if (rv_read) begin
            o_rv_rdata <= rsp.data;
        end
    end

    // Done follows the acknowledge itself, so the pending flag stays set
    // until the core has seen the ack and can drop its request
    assign o_rv_done = o_rv_ack;

endmodule

// File: verilog/wram_share_top.sv
// Shared work-RAM port for the console CPU and the soft core
// Request, array and response stages joined by two command buses

module wram_share_top import wram_pkg::*; #(
    parameter cpu_addr_t CPU_WINDOW_BASE = 16'h6000,
    parameter rv_addr_t  RV_WINDOW_BASE  = 23'h706000
) (
    input  logic       i_clk,
    input  logic       i_resetn,
    input  logic       i_wram_load_ongoing,
    // CPU side, sampled every edge
    input  logic       i_cpu_valid,
    input  logic       i_cpu_we,
    input  cpu_addr_t  i_cpu_addr,
    input  wram_data_t i_cpu_wdata,
    output logic       o_cpu_rvalid,
    output wram_data_t o_cpu_rdata,
    // Soft-core side, request held until ack
    input  logic       i_rv_req,
    input  logic       i_rv_we,
    input  rv_addr_t   i_rv_addr,
    input  wram_data_t i_rv_wdata,
    output logic       o_rv_ack,
    output wram_data_t o_rv_rdata
);

    wram_cmd_if cmd_bus ();
    wram_cmd_if rsp_bus ();

    logic rv_done;

    wram_request_stage #(
        .CPU_WINDOW_BASE (CPU_WINDOW_BASE),
        .RV_WINDOW_BASE  (RV_WINDOW_BASE)
    ) u_request (
        .i_clk               (i_clk),
        .i_resetn            (i_resetn),
        .i_wram_load_ongoing (i_wram_load_ongoing),
        .i_cpu_valid         (i_cpu_valid),
        .i_cpu_we            (i_cpu_we),
        .i_cpu_addr          (i_cpu_addr),
        .i_cpu_wdata         (i_cpu_wdata),
        .i_rv_req            (i_rv_req),
        .i_rv_we             (i_rv_we),
        .i_rv_addr           (i_rv_addr),
        .i_rv_wdata          (i_rv_wdata),
        .i_rv_done           (rv_done),
        .cmd                 (cmd_bus.sender)
    );

    wram_array_stage u_array (
        .i_clk    (i_clk),
        .i_resetn (i_resetn),
        .cmd      (cmd_bus.receiver),
        .rsp      (rsp_bus.sender)
    );

    wram_response_stage u_response (
        .i_clk        (i_clk),
        .i_resetn     (i_resetn),
        .rsp          (rsp_bus.receiver),
        .o_cpu_rvalid (o_cpu_rvalid),
        .o_cpu_rdata  (o_cpu_rdata),
        .o_rv_ack     (o_rv_ack),
        .o_rv_rdata   (o_rv_rdata),
        .o_rv_done    (rv_done)
    );

endmodule

// File: testbench/wram_share_properties.sv
// Concurrent assertions on the stage buses and the soft-core handshake
// Bound into the request stage and the response stage

module wram_share_properties import wram_pkg::*; (
    input logic        i_clk,
    input logic        i_resetn,
    input logic        rv_issue,
    input logic        rv_done,
    input logic        cmd_valid,
    input wram_index_t cmd_index,
    input logic        rv_ack,
    input logic        out_valid
);

    // Soft-core commands between issue and done
    logic [1:0] rv_in_flight;

    always_ff @(posedge i_clk) begin
        if (!i_resetn) begin
            rv_in_flight <= '0;
        end else begin
            rv_in_flight <= rv_in_flight + 2'(rv_issue) - 2'(rv_done);
        end
    end

    a_one_rv_in_flight: assert property (@(posedge i_clk) disable iff (!i_resetn)
        rv_in_flight <= 2'd1)
        else $error("more than one soft-core command in flight");

    // Index type covers the whole RAM, so a known value is in range
    a_index_known: assert property (@(posedge i_clk) disable iff (!i_resetn)
        cmd_valid |-> !$isunknown(cmd_index))
        else $error("command index unknown or out of range");

    a_ack_single: assert property (@(posedge i_clk) disable iff (!i_resetn)
        rv_ack |=> !rv_ack)
        else $error("soft-core acknowledge held for two cycles");

    a_quiet_after_reset: assert property (@(posedge i_clk)
        !i_resetn |=> !rv_ack && !out_valid)
        else $error("valid or acknowledge high right after reset");

endmodule

// Done is the acknowledge itself, so it stands in for o_rv_ack here
bind wram_request_stage wram_share_properties u_request_props (
    .i_clk     (i_clk),
    .i_resetn  (i_resetn),
    .rv_issue  (cmd.valid && cmd.src == wram_pkg::SRC_RV),
    .rv_done   (i_rv_done),
    .cmd_valid (cmd.valid),
    .cmd_index (cmd.index),
    .rv_ack    (i_rv_done),
    .out_valid (cmd.valid)
);

// Soft-core results count from arrival until the done feedback
bind wram_response_stage wram_share_properties u_response_props (
    .i_clk     (i_clk),
    .i_resetn  (i_resetn),
    .rv_issue  (rsp.valid && rsp.src == wram_pkg::SRC_RV),
    .rv_done   (o_rv_done),
    .cmd_valid (rsp.valid),
    .cmd_index (rsp.index),
    .rv_ack    (o_rv_ack),
    .out_valid (o_cpu_rvalid)
);

// File: testbench/tb_wram_share.sv
// Testbench for the shared work-RAM port
// Vector-driven stimulus, reference byte model, timeout and verdict

module tb_wram_share import wram_pkg::*;;

    typedef enum logic [3:0] {
        CPU_WR  = 4'h1,
        CPU_RD  = 4'h2,
        RV_WR   = 4'h3,
        RV_RD   = 4'h4,
        BOTH_WR = 4'h5
    } vec_op_e;

    localparam int CPU_BASE    = 'h6000;
    localparam int RV_BASE     = 'h706000;
    localparam int FIELDS      = 7;
    localparam int MAX_VECTORS = 64;

    logic       i_clk = 1'b0;
    logic       i_resetn;
    logic       i_wram_load_ongoing;
    logic       i_cpu_valid;
    logic       i_cpu_we;
    cpu_addr_t  i_cpu_addr;
    wram_data_t i_cpu_wdata;
    logic       o_cpu_rvalid;
    wram_data_t o_cpu_rdata;
    logic       i_rv_req;
    logic       i_rv_we;
    rv_addr_t   i_rv_addr;
    wram_data_t i_rv_wdata;
    logic       o_rv_ack;
    wram_data_t o_rv_rdata;

    logic [23:0] vec_mem [MAX_VECTORS*FIELDS];
    wram_data_t  model_mem [WRAM_DEPTH];
    int          vec_count;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    wram_share_top DUT (.*);

    always #2 i_clk = ~i_clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge i_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            abort_run("timeout waiting for response");
        end
    end

    task automatic check_data(input string name, input wram_data_t got, input wram_data_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run("read byte does not match the reference model");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run("output flag has the wrong level");
        end
    endtask

    task automatic check_latency(input int edges, input int want);
        if (edges != want) begin
            abort_run($sformatf("response came %0d edges after the request, not %0d",
                                edges, want));
        end
    endtask

    // Window rules: base inclusive, end exclusive
    function automatic bit cpu_in_window(input cpu_addr_t addr);
        return int'(addr) >= CPU_BASE && int'(addr) < CPU_BASE + WRAM_DEPTH;
    endfunction

    function automatic bit rv_in_window(input rv_addr_t addr);
        return int'(addr) >= RV_BASE && int'(addr) < RV_BASE + WRAM_DEPTH;
    endfunction

    // CPU read result, or nothing after 5 edges
    task automatic wait_cpu_read(output int edges, output logic seen);
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < 5) begin
            @(posedge i_clk);
            i_cpu_valid <= 1'b0;
            edges++;
            @(negedge i_clk);
            seen = o_cpu_rvalid;
        end
    endtask

    // Soft-core request held until ack, then dropped
    task automatic wait_rv_ack(output int edges, output wram_data_t rdata);
        logic seen;
        edges = 0;
        seen  = 1'b0;
        while (!seen) begin
            @(posedge i_clk);
            i_cpu_valid <= 1'b0;
            edges++;
            @(negedge i_clk);
            seen  = o_rv_ack;
            rdata = o_rv_rdata;
        end
        @(posedge i_clk);
        i_rv_req <= 1'b0;
    endtask

    task automatic run_vector(input int n);
        vec_op_e    op;
        logic       load;
        cpu_addr_t  cpu_addr;
        wram_data_t cpu_data;
        rv_addr_t   rv_addr;
        wram_data_t rv_data;
        wram_data_t exp_byte;
        wram_data_t model_byte;
        wram_data_t rdata;
        int         edges;
        logic       seen;
        bit         cpu_first;
        op       = vec_op_e'(vec_mem[n*FIELDS][3:0]);
        load     = vec_mem[n*FIELDS+1][0];
        cpu_addr = cpu_addr_t'(vec_mem[n*FIELDS+2]);
        cpu_data = wram_data_t'(vec_mem[n*FIELDS+3]);
        rv_addr  = rv_addr_t'(vec_mem[n*FIELDS+4]);
        rv_data  = wram_data_t'(vec_mem[n*FIELDS+5]);
        exp_byte = wram_data_t'(vec_mem[n*FIELDS+6]);
        if (!(op inside {CPU_WR, CPU_RD, RV_WR, RV_RD, BOTH_WR})) begin
            abort_run($sformatf("unknown opcode in vector %0d", n));
        end
        @(posedge i_clk);
        i_wram_load_ongoing <= load;
        i_cpu_valid <= op inside {CPU_WR, CPU_RD, BOTH_WR};
        i_cpu_we    <= op != CPU_RD;
        i_cpu_addr  <= cpu_addr;
        i_cpu_wdata <= cpu_data;
        i_rv_req    <= op inside {RV_WR, RV_RD, BOTH_WR};
        i_rv_we     <= op != RV_RD;
        i_rv_addr   <= rv_addr;
        i_rv_wdata  <= rv_data;
        case (op)
            CPU_WR: begin
                @(posedge i_clk);
                i_cpu_valid <= 1'b0;
                if (cpu_in_window(cpu_addr)) begin
                    model_mem[wram_index_t'(int'(cpu_addr) - CPU_BASE)] = cpu_data;
                end
            end
            CPU_RD: begin
                wait_cpu_read(edges, seen);
                if (cpu_in_window(cpu_addr)) begin
                    model_byte = model_mem[wram_index_t'(int'(cpu_addr) - CPU_BASE)];
                    check_data("vector expected byte", exp_byte, model_byte);
                    check_flag("o_cpu_rvalid", seen, 1'b1);
                    check_latency(edges, 3);
                    check_data("o_cpu_rdata", o_cpu_rdata, model_byte);
                end else begin
                    check_flag("o_cpu_rvalid", seen, 1'b0);
                end
            end
            default: begin
                wait_rv_ack(edges, rdata);
                // CPU takes the slot first unless a load is running
                cpu_first = op == BOTH_WR && !load && cpu_in_window(cpu_addr);
                check_latency(edges, cpu_first ? 4 : 3);
                if (cpu_first) begin
                    model_mem[wram_index_t'(int'(cpu_addr) - CPU_BASE)] = cpu_data;
                end
                if (op != RV_RD && rv_in_window(rv_addr)) begin
                    model_mem[wram_index_t'(int'(rv_addr) - RV_BASE)] = rv_data;
                end
                if (op == RV_RD) begin
                    model_byte = rv_in_window(rv_addr) ?
                                 model_mem[wram_index_t'(int'(rv_addr) - RV_BASE)] : 8'h00;
                    check_data("vector expected byte", exp_byte, model_byte);
                    check_data("o_rv_rdata", rdata, model_byte);
                end
            end
        endcase
    endtask

    initial begin
        i_resetn            = 1'b0;
        i_wram_load_ongoing = 1'b0;
        i_cpu_valid         = 1'b0;
        i_cpu_we            = 1'b0;
        i_cpu_addr          = '0;
        i_cpu_wdata         = '0;
        i_rv_req            = 1'b0;
        i_rv_we             = 1'b0;
        i_rv_addr           = '0;
        i_rv_wdata          = '0;
        // All-ones opcode word marks the end of the vector list
        for (int i = 0; i < MAX_VECTORS*FIELDS; i++) begin
            vec_mem[i] = '1;
        end
        $readmemh("testbench/wram_share_vectors.hex", vec_mem);
        vec_count = 0;
        while (vec_count < MAX_VECTORS && vec_mem[vec_count*FIELDS] !== '1) begin
            vec_count++;
        end
        if (vec_count == 0) begin
            abort_run("no vectors found in the vector file");
        end
        cycle_limit = 10 * vec_count + 20;
        repeat (2) @(posedge i_clk);
        i_resetn <= 1'b1;
        for (int n = 0; n < vec_count; n++) begin
            run_vector(n);
        end
        $display("test passed");
        $finish;
    end

endmodule

// File: testbench/wram_share_vectors.hex
// op load cpu_addr cpu_data rv_addr rv_data expected_read_byte
// op: 1 CPU_WR, 2 CPU_RD, 3 RV_WR, 4 RV_RD, 5 BOTH_WR
1 0 6010 5a 000000 00 00
2 0 6010 00 000000 00 5a
1 0 7fff c3 000000 00 00
2 0 7fff 00 000000 00 c3
3 0 0000 00 706020 a7 00
4 0 0000 00 706020 00 a7
2 0 6020 00 000000 00 a7
3 0 0000 00 706000 3c 00
2 0 6000 00 000000 00 3c
5 0 6030 11 706030 22 00
2 0 6030 00 000000 00 22
4 0 0000 00 706030 00 22
5 0 6040 33 706050 44 00
2 0 6040 00 000000 00 33
4 0 0000 00 706050 00 44
1 0 6060 55 000000 00 00
5 1 6060 66 706070 77 00
2 0 6060 00 000000 00 55
2 0 6070 00 000000 00 77
5 1 6080 aa 706080 bb 00
2 1 6080 00 000000 00 bb
4 0 0000 00 706080 00 bb
2 0 8000 00 000000 00 00
2 0 5fff 00 000000 00 00
4 0 0000 00 708000 00 00
4 0 0000 00 000000 00 00
3 0 0000 00 708010 ee 00
1 0 7ff0 12 000000 00 00
1 0 5ff0 ee 000000 00 00
2 0 7ff0 00 000000 00 12
2 0 6010 00 000000 00 5a
4 0 0000 00 706020 00 a7
4 0 0000 00 707fff 00 c3

// File: sim.f
verilog/wram_pkg.sv
verilog/wram_cmd_if.sv
verilog/wram_request_stage.sv
verilog/wram_array_stage.sv
verilog/wram_response_stage.sv
verilog/wram_share_top.sv
testbench/wram_share_properties.sv
testbench/tb_wram_share.sv

// File: Bender.yml
package:
  name: wram_share

sources:
  - verilog/wram_pkg.sv
  - verilog/wram_cmd_if.sv
  - verilog/wram_request_stage.sv
  - verilog/wram_array_stage.sv
  - verilog/wram_response_stage.sv
  - verilog/wram_share_top.sv
  - target: simulation
    files:
      - testbench/wram_share_properties.sv
      - testbench/tb_wram_share.sv
